// File: hdl/portalPkg.sv
package portalPkg;

  // address decode
  localparam int PORTAL_SEL_BIT = 12;  // 0 request, 1 indication
  localparam int PAGE_MSB = 11;
  localparam int PAGE_LSB = 5;  // page field zero means control page
  localparam int PAGE_W = PAGE_MSB - PAGE_LSB + 1;

  localparam int OFFSET_W = 5;  // word offset inside a page
  localparam int REG_W = 32;

  typedef logic [OFFSET_W-1:0] offsetT;

  // control page
  localparam offsetT CTRL_INT_STATUS   = 5'h00;
  localparam offsetT CTRL_INT_ENABLE   = 5'h04;
  localparam offsetT CTRL_NUM_TILES    = 5'h08;
  localparam offsetT CTRL_QUEUE_STATUS = 5'h0C;
  localparam offsetT CTRL_PORTAL_ID    = 5'h10;
  localparam offsetT CTRL_NUM_PORTALS  = 5'h14;

  // user page
  localparam offsetT USER_DATA   = 5'h00;
  localparam offsetT USER_STATUS = 5'h04;  // bit0 is room in the echo queue

  localparam logic [REG_W-1:0] REQ_PORTAL_ID = 32'd5;
  localparam logic [REG_W-1:0] IND_PORTAL_ID = 32'd6;

  localparam logic [REG_W-1:0] NUM_TILES   = 32'd1;
  localparam logic [REG_W-1:0] NUM_PORTALS = 32'd2;

endpackage

// File: hdl/axiBusPkg.sv
package axiBusPkg;
  import portalPkg::*;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W = 6;  // upper id bits are not carried
  localparam int LEN_W = 4;  // beats minus one
  localparam int COUNT_W = LEN_W + 1;  // holds 16

  // AR and AW
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [LEN_W-1:0]  len;
  } addrReqT;

  typedef logic [DATA_W-1:0] wDataT;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic              last;
  } rRespT;

  typedef struct packed {
    logic [ID_W-1:0] id;
  } bRespT;

  // one word of a split burst
  typedef struct packed {
    logic [OFFSET_W-1:0] offset;
    logic [COUNT_W-1:0]  remaining;  // beats left, this one included
    logic [ID_W-1:0]     id;
    logic                last;
    logic                ctrlPage;
    logic                indPortal;
  } beatT;

endpackage

// File: hdl/fifo1.sv
`timescale 1ns/1ps

module fifo1 #(
  parameter int WIDTH = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             inValid,
  input  logic [WIDTH-1:0] inData,
  output logic             inReady,
  output logic             outValid,
  output logic [WIDTH-1:0] outData,
  input  logic             outReady
);

  logic full;
  logic [WIDTH-1:0] dataReg;

  assign inReady = !full;  // accepts only when empty
  assign outValid = full;
  assign outData = dataReg;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (inValid && inReady) begin
      full <= 1'b1;
    end else if (outValid && outReady) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (inValid && inReady) begin
      dataReg <= inData;
    end
  end

  // upstream holds its word until there is room
  assert property (@(posedge CLK) disable iff (!nRST)
    inValid && !inReady |=> inValid && $stable(inData));

endmodule

// File: hdl/burstSplitter.sv
`timescale 1ns/1ps

module burstSplitter import axiBusPkg::*, portalPkg::*; (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    reqValid,
  input  addrReqT req,
  output logic    reqPop,
  output logic    beatValid,
  output beatT    beat,
  input  logic    beatReady
);

  logic inBurst;  // low on the first beat of a burst
  logic [OFFSET_W-1:0] offsetReg;
  logic [COUNT_W-1:0] countReg;
  logic [OFFSET_W-1:0] curOffset;
  logic [COUNT_W-1:0] curCount;
  logic fire;

  assign curOffset = inBurst ? offsetReg : req.addr[OFFSET_W-1:0];
  assign curCount = inBurst ? countReg : COUNT_W'(req.len) + COUNT_W'(1);

  always_comb begin
    beat.offset = curOffset;
    beat.remaining = curCount;
    beat.id = req.id;
    beat.last = curCount == COUNT_W'(1);
    beat.ctrlPage = req.addr[PAGE_MSB:PAGE_LSB] == PAGE_W'(0);
    beat.indPortal = req.addr[PORTAL_SEL_BIT];
  end

  assign beatValid = reqValid;
  assign fire = beatValid && beatReady;
  assign reqPop = fire && beat.last;  // request leaves with its last beat

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      inBurst <= 1'b0;
    end else if (fire) begin
      inBurst <= !beat.last;
    end
  end

  always_ff @(posedge CLK) begin
    if (fire) begin
      offsetReg <= curOffset + OFFSET_W'(4);  // wraps in the page
      countReg <= curCount - COUNT_W'(1);
    end
  end

  // a burst never runs past its length
  assert property (@(posedge CLK) disable iff (!nRST)
    inBurst |-> reqValid && countReg != '0);

endmodule

// File: hdl/portalControl.sv
`timescale 1ns/1ps

module portalControl import portalPkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  input  logic [OFFSET_W-1:0] offset,
  input  logic             indPortal,
  output logic [REG_W-1:0] rdData,
  input  logic             wrEnable,
  input  logic             wrBit,
  input  logic             echoNotEmpty,
  output logic             interrupt
);

  logic intEnable;

  always_comb begin
    case (offset)
      CTRL_INT_STATUS, CTRL_QUEUE_STATUS: begin
        rdData = REG_W'(echoNotEmpty);
      end
      CTRL_INT_ENABLE: begin
        rdData = REG_W'(intEnable);
      end
      CTRL_NUM_TILES: begin
        rdData = NUM_TILES;
      end
      CTRL_PORTAL_ID: begin
        rdData = indPortal ? IND_PORTAL_ID : REQ_PORTAL_ID;
      end
      CTRL_NUM_PORTALS: begin
        rdData = NUM_PORTALS;
      end
      default: begin
        rdData = '0;  // counters and holes
      end
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intEnable <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      if (wrEnable) begin
        intEnable <= wrBit;
      end
      interrupt <= intEnable && echoNotEmpty;  // one cycle behind the queue
    end
  end

endmodule

// File: hdl/userEcho.sv
`timescale 1ns/1ps

module userEcho import portalPkg::*; #(
  parameter int ECHO_DEPTH = 4  // power of two, at least 2
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             push,
  input  logic [REG_W-1:0] pushData,
  input  logic             pop,
  output logic [REG_W-1:0] popData,
  output logic             notEmpty,
  output logic             notFull
);

  localparam int PTR_W = $clog2(ECHO_DEPTH);

  logic [REG_W-1:0] mem [ECHO_DEPTH];
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W:0] count;
  logic doPush;
  logic doPop;

  assign notEmpty = count != '0;
  assign notFull = count != (PTR_W + 1)'(ECHO_DEPTH);
  assign doPush = push && notFull;  // drop when full
  assign doPop = pop && notEmpty;
  assign popData = notEmpty ? mem[rdPtr] : '0;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(doPush) - (PTR_W + 1)'(doPop);
    end
  end

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    count <= (PTR_W + 1)'(ECHO_DEPTH));

endmodule

// File: hdl/portalBridge.sv
`timescale 1ns/1ps

module portalBridge import axiBusPkg::*, portalPkg::*; #(
  parameter int ECHO_DEPTH = 4
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    arValid,
  input  addrReqT ar,
  output logic    arReady,
  input  logic    awValid,
  input  addrReqT aw,
  output logic    awReady,
  input  logic    wValid,
  input  wDataT   w,
  output logic    wReady,
  output logic    rValid,
  output rRespT   r,
  input  logic    rReady,
  output logic    bValid,
  output bRespT   b,
  input  logic    bReady,
  output logic    interrupt
);

  addrReqT arHead;
  addrReqT awHead;
  logic arHeadValid;
  logic awHeadValid;
  logic arPop;
  logic awPop;
  beatT rdSplit;
  beatT wrSplit;
  beatT rdBeat;
  beatT wrBeat;
  logic rdSplitValid;
  logic wrSplitValid;
  logic rdSplitReady;
  logic wrSplitReady;
  logic rdBeatValid;
  logic wrBeatValid;
  wDataT wHead;
  logic wHeadValid;
  rRespT rdResp;
  bRespT wrResp;
  logic rDataReady;
  logic bRespReady;
  logic readFire;
  logic writeFire;
  logic [REG_W-1:0] ctrlData;
  logic [REG_W-1:0] userData;
  logic [REG_W-1:0] echoData;
  logic echoPush;
  logic echoPop;
  logic echoNotEmpty;
  logic echoNotFull;
  logic intEnWrite;

  fifo1 #(.WIDTH($bits(addrReqT))) arQueue (
    .CLK(CLK), .nRST(nRST),
    .inValid(arValid), .inData(ar), .inReady(arReady),
    .outValid(arHeadValid), .outData(arHead), .outReady(arPop)
  );

  fifo1 #(.WIDTH($bits(addrReqT))) awQueue (
    .CLK(CLK), .nRST(nRST),
    .inValid(awValid), .inData(aw), .inReady(awReady),
    .outValid(awHeadValid), .outData(awHead), .outReady(awPop)
  );

  burstSplitter readSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(arHeadValid), .req(arHead), .reqPop(arPop),
    .beatValid(rdSplitValid), .beat(rdSplit), .beatReady(rdSplitReady)
  );

  burstSplitter writeSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(awHeadValid), .req(awHead), .reqPop(awPop),
    .beatValid(wrSplitValid), .beat(wrSplit), .beatReady(wrSplitReady)
  );

  fifo1 #(.WIDTH($bits(beatT))) readBeatQ (
    .CLK(CLK), .nRST(nRST),
    .inValid(rdSplitValid), .inData(rdSplit), .inReady(rdSplitReady),
    .outValid(rdBeatValid), .outData(rdBeat), .outReady(readFire)
  );

  fifo1 #(.WIDTH($bits(beatT))) writeBeatQ (
    .CLK(CLK), .nRST(nRST),
    .inValid(wrSplitValid), .inData(wrSplit), .inReady(wrSplitReady),
    .outValid(wrBeatValid), .outData(wrBeat), .outReady(writeFire)
  );

  fifo1 #(.WIDTH($bits(wDataT))) wDataQ (
    .CLK(CLK), .nRST(nRST),
    .inValid(wValid), .inData(w), .inReady(wReady),
    .outValid(wHeadValid), .outData(wHead), .outReady(writeFire)
  );

  fifo1 #(.WIDTH($bits(rRespT))) rDataQ (
    .CLK(CLK), .nRST(nRST),
    .inValid(readFire), .inData(rdResp), .inReady(rDataReady),
    .outValid(rValid), .outData(r), .outReady(rReady)
  );

  fifo1 #(.WIDTH($bits(bRespT))) bRespQ (
    .CLK(CLK), .nRST(nRST),
    .inValid(writeFire && wrBeat.last), .inData(wrResp), .inReady(bRespReady),
    .outValid(bValid), .outData(b), .outReady(bReady)
  );

  // read side
  assign readFire = rdBeatValid && rDataReady;
  assign echoPop = readFire && !rdBeat.ctrlPage && rdBeat.indPortal
                   && rdBeat.offset == USER_DATA;

  always_comb begin
    if (rdBeat.offset == USER_DATA && rdBeat.indPortal) begin
      userData = echoData;
    end else if (rdBeat.offset == USER_STATUS) begin
      userData = REG_W'(echoNotFull);
    end else begin
      userData = '0;
    end
  end

  assign rdResp = '{data: rdBeat.ctrlPage ? ctrlData : userData,
                    id: rdBeat.id,
                    last: rdBeat.last};

  // a last write beat also needs room for B
  assign writeFire = wrBeatValid && wHeadValid && (!wrBeat.last || bRespReady);
  assign wrResp = '{id: wrBeat.id};
  assign intEnWrite = writeFire && wrBeat.ctrlPage && wrBeat.offset == CTRL_INT_ENABLE;
  assign echoPush = writeFire && !wrBeat.ctrlPage && !wrBeat.indPortal
                    && wrBeat.offset == USER_DATA;

  portalControl control (
    .CLK(CLK), .nRST(nRST),
    .offset(rdBeat.offset), .indPortal(rdBeat.indPortal), .rdData(ctrlData),
    .wrEnable(intEnWrite), .wrBit(wHead[0]),
    .echoNotEmpty(echoNotEmpty), .interrupt(interrupt)
  );

  userEcho #(.ECHO_DEPTH(ECHO_DEPTH)) echo (
    .CLK(CLK), .nRST(nRST),
    .push(echoPush), .pushData(wHead),
    .pop(echoPop), .popData(echoData),
    .notEmpty(echoNotEmpty), .notFull(echoNotFull)
  );

endmodule

// File: tests/portalChecker.sv
`timescale 1ns/1ps

module portalChecker import axiBusPkg::*, portalPkg::*; #(
  parameter int ECHO_DEPTH = 4
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    arValid,
  input  addrReqT ar,
  input  logic    arReady,
  input  logic    awValid,
  input  addrReqT aw,
  input  logic    awReady,
  input  logic    wValid,
  input  wDataT   w,
  input  logic    wReady,
  input  logic    rValid,
  input  rRespT   r,
  input  logic    rReady,
  input  logic    bValid,
  input  bRespT   b,
  input  logic    bReady,
  input  logic    interrupt,
  output int      errorCount,
  output int      readBeats,
  output int      writeBursts
);

  addrReqT arOpen[$];
  addrReqT awOpen[$];
  wDataT wSeen[$];
  logic [REG_W-1:0] echoModel[$];  // words the user block should hold
  logic enableModel;
  int beatIdx;  // beat of the oldest open read
  int intWait;  // cycles until interrupt is settled
  logic afterReset;

  function automatic offsetT beatOffset(addrReqT req, int idx);
    return req.addr[OFFSET_W-1:0] + OFFSET_W'(idx * 4);  // wraps in 5 bits
  endfunction

  function automatic logic [REG_W-1:0] ctrlRead(offsetT off, logic ind);
    logic [REG_W-1:0] val;
    val = '0;
    if (off == 5'h00 || off == 5'h0C) begin
      val[0] = echoModel.size() != 0;
    end else if (off == 5'h04) begin
      val[0] = enableModel;
    end else if (off == 5'h08) begin
      val = 32'd1;
    end else if (off == 5'h10) begin
      val = ind ? 32'd6 : 32'd5;
    end else if (off == 5'h14) begin
      val = 32'd2;
    end
    return val;
  endfunction

  task automatic compare(string name, logic [REG_W-1:0] expVal, logic [REG_W-1:0] gotVal);
    if (gotVal !== expVal) begin
      $display("Error %s exp %h got %h", name, expVal, gotVal);
      errorCount++;
    end
  endtask

  task automatic failure(string what);
    $display("%s at time %0t", what, $time);
    errorCount++;
  endtask

  task automatic checkRead();
    addrReqT req;
    offsetT off;
    logic ind;
    logic expLast;
    logic [REG_W-1:0] expData;
    if (arOpen.size() == 0) begin
      failure("an R beat came with no read burst open");
      return;
    end
    req = arOpen[0];
    off = beatOffset(req, beatIdx);
    ind = req.addr[PORTAL_SEL_BIT];
    expLast = beatIdx == int'(req.len);
    expData = '0;
    if (req.addr[PAGE_MSB:PAGE_LSB] == '0) begin
      expData = ctrlRead(off, ind);
    end else if (off == 5'h00 && ind) begin
      if (echoModel.size() != 0) begin
        expData = echoModel.pop_front();  // empty pop reads 0
      end
    end else if (off == 5'h04) begin
      expData[0] = echoModel.size() < ECHO_DEPTH;
    end
    compare("r.data", expData, r.data);
    compare("r.id", REG_W'(req.id), REG_W'(r.id));
    compare("r.last", REG_W'(expLast), REG_W'(r.last));
    readBeats++;
    if (expLast) begin
      void'(arOpen.pop_front());
      beatIdx = 0;
      intWait = 2;
    end else begin
      beatIdx++;
    end
  endtask

  task automatic checkWrite();
    addrReqT req;
    offsetT off;
    wDataT word;
    int idx;
    if (awOpen.size() == 0) begin
      failure("a B response came with no write burst open");
      return;
    end
    req = awOpen.pop_front();
    if (wSeen.size() != int'(req.len) + 1) begin
      failure("the B response does not match the number of W words taken");
    end
    for (idx = 0; idx <= int'(req.len); idx++) begin
      word = '0;
      if (wSeen.size() != 0) begin
        word = wSeen.pop_front();
      end
      off = beatOffset(req, idx);
      if (req.addr[PAGE_MSB:PAGE_LSB] == '0) begin
        if (off == 5'h04) begin
          enableModel = word[0];
        end
      end else if (!req.addr[PORTAL_SEL_BIT] && off == 5'h00) begin
        if (echoModel.size() < ECHO_DEPTH) begin
          echoModel.push_back(word);  // full queue drops the word
        end
      end
    end
    compare("b.id", REG_W'(req.id), REG_W'(b.id));
    writeBursts++;
    intWait = 2;
  endtask

  always @(posedge CLK) begin
    if (!nRST) begin
      arOpen.delete();
      awOpen.delete();
      wSeen.delete();
      echoModel.delete();
      enableModel = 1'b0;
      beatIdx = 0;
      intWait = 0;
      afterReset = 1'b1;
    end else begin
      if (afterReset) begin
        compare("rValid", '0, REG_W'(rValid));
        compare("bValid", '0, REG_W'(bValid));
        compare("interrupt", '0, REG_W'(interrupt));
        compare("arReady", 32'd1, REG_W'(arReady));
        compare("awReady", 32'd1, REG_W'(awReady));
        compare("wReady", 32'd1, REG_W'(wReady));
        afterReset = 1'b0;
      end
      if (intWait > 0) begin
        intWait--;
        if (intWait == 0) begin
          compare("interrupt", REG_W'(enableModel && echoModel.size() != 0), REG_W'(interrupt));
        end
      end
      if (arValid && arReady) arOpen.push_back(ar);
      if (awValid && awReady) awOpen.push_back(aw);
      if (wValid && wReady) wSeen.push_back(w);
      if (rValid && rReady) checkRead();
      if (bValid && bReady) checkWrite();
    end
  end

endmodule

// File: tests/tbPortal.sv
`timescale 1ns/1ps

module tbPortal import axiBusPkg::*, portalPkg::*; ();

  localparam int ECHO_DEPTH = 4;
  localparam int NUM_TRANS = 300;
  localparam int SWEEP_TRANS = 2;  // control page reads on both portals
  localparam int CYCLE_LIMIT = (NUM_TRANS + SWEEP_TRANS) * 80;

  logic CLK;
  logic nRST;
  logic arValid;
  addrReqT ar;
  logic arReady;
  logic awValid;
  addrReqT aw;
  logic awReady;
  logic wValid;
  wDataT w;
  logic wReady;
  logic rValid;
  rRespT r;
  logic rReady;
  logic bValid;
  bRespT b;
  logic bReady;
  logic interrupt;
  int errorCount;
  int readBeats;
  int writeBursts;
  int cycleCount;

  portalBridge #(.ECHO_DEPTH(ECHO_DEPTH)) i_dut (.*);

  portalChecker #(.ECHO_DEPTH(ECHO_DEPTH)) scoreboard (.*);

  always #4 CLK = !CLK;

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with a transaction still open", cycleCount);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic addrReqT randomReq();
    addrReqT req;
    req.addr = $urandom;  // portal bit and upper bits at random
    if ($urandom_range(0, 1) == 1) begin
      req.addr[PAGE_MSB:PAGE_LSB] = '0;
    end else begin
      req.addr[PAGE_MSB:PAGE_LSB] = PAGE_W'($urandom_range(1, 127));
    end
    case ($urandom_range(0, 3))
      0, 1: req.addr[OFFSET_W-1:0] = 5'h00;
      2: req.addr[OFFSET_W-1:0] = 5'h04;
      default: req.addr[OFFSET_W-1:0] = OFFSET_W'($urandom);
    endcase
    req.id = ID_W'($urandom);
    req.len = LEN_W'($urandom_range(0, 3));  // 1 to 4 beats
    return req;
  endfunction

  task automatic readBurst(input addrReqT req);
    int seen;
    seen = 0;
    arValid <= 1'b1;
    ar <= req;
    @(posedge CLK);
    while (!arReady) @(posedge CLK);
    arValid <= 1'b0;
    while (seen <= int'(req.len)) begin
      rReady <= 1'($urandom_range(0, 1));
      @(posedge CLK);
      if (rValid && rReady) seen++;
    end
    rReady <= 1'b0;
  endtask

  task automatic writeBurst(input addrReqT req);
    int idx;
    logic gotB;
    awValid <= 1'b1;
    aw <= req;
    @(posedge CLK);
    while (!awReady) @(posedge CLK);
    awValid <= 1'b0;
    for (idx = 0; idx <= int'(req.len); idx++) begin
      wValid <= 1'b1;
      w <= $urandom;
      @(posedge CLK);
      while (!wReady) @(posedge CLK);
    end
    wValid <= 1'b0;
    gotB = 1'b0;
    while (!gotB) begin
      bReady <= 1'($urandom_range(0, 1));
      @(posedge CLK);
      gotB = bValid && bReady;
    end
    bReady <= 1'b0;
  endtask

  initial begin
    addrReqT req;
    int n;
    void'($urandom(32'h09a7_43d9));
    CLK = 1'b0;
    nRST = 1'b0;
    arValid = 1'b0;
    ar = '0;
    awValid = 1'b0;
    aw = '0;
    wValid = 1'b0;
    w = '0;
    rReady = 1'b0;
    bReady = 1'b0;
    cycleCount = 0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    for (n = 0; n < SWEEP_TRANS; n++) begin
      req = '0;
      req.addr[PORTAL_SEL_BIT] = n[0];
      req.id = ID_W'(n + 1);
      req.len = 4'd7;  // offsets 0x00 to 0x1C
      readBurst(req);
    end
    for (n = 0; n < NUM_TRANS; n++) begin
      req = randomReq();
      if ($urandom_range(0, 1) == 1) begin
        readBurst(req);
      end else begin
        writeBurst(req);
      end
    end
    repeat (4) @(posedge CLK);
    $display("Checked %0d read beats and %0d write bursts, %0d errors",
             readBeats, writeBursts, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/portalPkg.sv
hdl/axiBusPkg.sv
hdl/fifo1.sv
hdl/burstSplitter.sv
hdl/portalControl.sv
hdl/userEcho.sv
hdl/portalBridge.sv
tests/portalChecker.sv
tests/tbPortal.sv

// File: runSim.sh
#!/bin/bash
# build and run the portal bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbPortal -f vlog.f -o simPortal \
  && ./obj_dir/simPortal > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "failures found in sim.log"; exit 1; } \
  || echo "no failures found in sim.log"
